// File: src/w3d_interconnect_cfg.svh
`ifndef W3D_INTERCONNECT_CFG_SVH
`define W3D_INTERCONNECT_CFG_SVH

////////////////////////////////////////////////////////////
// Bus widths
`define W3D_ADDR_W 32
`define W3D_DATA_W 32

////////////////////////////////////////////////////////////
// Host data address map
`define W3D_DRAM_BASE 32'h0000_0000
`define W3D_DRAM_MASK 32'he000_0000
`define W3D_MMIO_BASE 32'h2000_0000 // Graphics control and external I/O
`define W3D_MMIO_MASK 32'he000_0000

// MMIO subregions
`define W3D_GFX_BASE 32'h2000_0000
`define W3D_GFX_MASK 32'hf000_0000
`define W3D_EXT_BASE 32'h3000_0000
`define W3D_EXT_MASK 32'hf000_0000

`define W3D_DRAM_MASTERS 3 // VRAM, host data, host instruction

`endif

// File: src/w3d_bus_pkg.sv
package w3d_bus_pkg;

	// Request opcode
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// Response status
	typedef enum logic {
		RESP_OKAY   = 1'b0,
		RESP_DECERR = 1'b1 // No target at this address
	} bus_resp_e;

endpackage

// File: src/w3d_map_pkg.sv
package w3d_map_pkg;

	// Host data address decode result
	typedef enum logic [1:0] {
		REG_DRAM = 2'd0,
		REG_MMIO = 2'd1,
		REG_NONE = 2'd2
	} region_e;

	// DRAM arbiter slots, in round-robin order
	typedef enum logic [1:0] {
		M_GFX_VRAM  = 2'd0,
		M_HOST_DBUS = 2'd1,
		M_HOST_IBUS = 2'd2
	} dram_master_e;

endpackage

// File: src/w3d_host_decoder.sv
`include "w3d_interconnect_cfg.svh"

module w3d_host_decoder
(
	input  logic                   clk,
	input  logic                   arst_n,

	input  logic                   host_req_valid,
	output logic                   host_req_ready,
	input  w3d_bus_pkg::bus_op_e   host_req_op,
	input  logic [`W3D_ADDR_W-1:0] host_req_addr,
	input  logic [`W3D_DATA_W-1:0] host_req_wdata,
	output logic                   host_rsp_valid,
	input  logic                   host_rsp_ready,
	output logic [`W3D_DATA_W-1:0] host_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e host_rsp_resp,

	output logic                   dram_req_valid,
	input  logic                   dram_req_ready,
	output w3d_bus_pkg::bus_op_e   dram_req_op,
	output logic [`W3D_ADDR_W-1:0] dram_req_addr,
	output logic [`W3D_DATA_W-1:0] dram_req_wdata,
	input  logic                   dram_rsp_valid,
	output logic                   dram_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] dram_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e dram_rsp_resp,

	output logic                   mmio_req_valid,
	input  logic                   mmio_req_ready,
	output w3d_bus_pkg::bus_op_e   mmio_req_op,
	output logic [`W3D_ADDR_W-1:0] mmio_req_addr,
	output logic [`W3D_DATA_W-1:0] mmio_req_wdata,
	input  logic                   mmio_rsp_valid,
	output logic                   mmio_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] mmio_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e mmio_rsp_resp
);

	import w3d_bus_pkg::*;
	import w3d_map_pkg::*;

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_DRAM,
		DEC_MMIO,
		DEC_ERR
	} dec_state_e;

	dec_state_e state;
	region_e    region;
	logic       idle;

	always_comb begin
		if ((host_req_addr & `W3D_DRAM_MASK) == `W3D_DRAM_BASE)
			region = REG_DRAM;
		else if ((host_req_addr & `W3D_MMIO_MASK) == `W3D_MMIO_BASE)
			region = REG_MMIO;
		else
			region = REG_NONE;
	end

	////////////////////////////////////////////////////////////
	// Request path open only while idle

	assign idle = state == DEC_IDLE;

	assign dram_req_valid = idle && host_req_valid && region == REG_DRAM;
	assign mmio_req_valid = idle && host_req_valid && region == REG_MMIO;

	assign dram_req_op    = host_req_op;
	assign dram_req_addr  = host_req_addr;
	assign dram_req_wdata = host_req_wdata;
	assign mmio_req_op    = host_req_op;
	assign mmio_req_addr  = host_req_addr;
	assign mmio_req_wdata = host_req_wdata;

	always_comb begin
		case (region)
			REG_DRAM: host_req_ready = idle && dram_req_ready;
			REG_MMIO: host_req_ready = idle && mmio_req_ready;
			default:  host_req_ready = idle; // Unmapped address always taken
		endcase
	end

	////////////////////////////////////////////////////////////
	// Response path

	always_comb begin
		host_rsp_valid = 1'b0;
		host_rsp_rdata = '0;
		host_rsp_resp  = RESP_OKAY;
		case (state)
			DEC_DRAM: begin
				host_rsp_valid = dram_rsp_valid;
				host_rsp_rdata = dram_rsp_rdata;
				host_rsp_resp  = dram_rsp_resp;
			end
			DEC_MMIO: begin
				host_rsp_valid = mmio_rsp_valid;
				host_rsp_rdata = mmio_rsp_rdata;
				host_rsp_resp  = mmio_rsp_resp;
			end
			DEC_ERR: begin
				host_rsp_valid = 1'b1;
				host_rsp_resp  = RESP_DECERR;
			end
			default: ;
		endcase
	end

	assign dram_rsp_ready = state == DEC_DRAM && host_rsp_ready;
	assign mmio_rsp_ready = state == DEC_MMIO && host_rsp_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DEC_IDLE;
		end else if (idle) begin
			if (host_req_valid && host_req_ready) begin
				case (region)
					REG_DRAM: state <= DEC_DRAM;
					REG_MMIO: state <= DEC_MMIO;
					default:  state <= DEC_ERR;
				endcase
			end
		end else if (host_rsp_valid && host_rsp_ready) begin
			state <= DEC_IDLE;
		end
	end

endmodule

// File: src/w3d_dram_arbiter.sv
`include "w3d_interconnect_cfg.svh"

module w3d_dram_arbiter
(
	input  logic                   clk,
	input  logic                   arst_n,

	input  logic                   gfx_vram_req_valid,
	output logic                   gfx_vram_req_ready,
	input  w3d_bus_pkg::bus_op_e   gfx_vram_req_op,
	input  logic [`W3D_ADDR_W-1:0] gfx_vram_req_addr,
	input  logic [`W3D_DATA_W-1:0] gfx_vram_req_wdata,
	output logic                   gfx_vram_rsp_valid,
	input  logic                   gfx_vram_rsp_ready,
	output logic [`W3D_DATA_W-1:0] gfx_vram_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e gfx_vram_rsp_resp,

	input  logic                   dbus_req_valid,
	output logic                   dbus_req_ready,
	input  w3d_bus_pkg::bus_op_e   dbus_req_op,
	input  logic [`W3D_ADDR_W-1:0] dbus_req_addr,
	input  logic [`W3D_DATA_W-1:0] dbus_req_wdata,
	output logic                   dbus_rsp_valid,
	input  logic                   dbus_rsp_ready,
	output logic [`W3D_DATA_W-1:0] dbus_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e dbus_rsp_resp,

	input  logic                   ibus_req_valid,
	output logic                   ibus_req_ready,
	input  logic [`W3D_ADDR_W-1:0] ibus_req_addr,
	output logic                   ibus_rsp_valid,
	input  logic                   ibus_rsp_ready,
	output logic [`W3D_DATA_W-1:0] ibus_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e ibus_rsp_resp,

	output logic                   dram_req_valid,
	input  logic                   dram_req_ready,
	output w3d_bus_pkg::bus_op_e   dram_req_op,
	output logic [`W3D_ADDR_W-1:0] dram_req_addr,
	output logic [`W3D_DATA_W-1:0] dram_req_wdata,
	input  logic                   dram_rsp_valid,
	output logic                   dram_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] dram_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e dram_rsp_resp
);

	import w3d_bus_pkg::*;
	import w3d_map_pkg::*;

	localparam int N = `W3D_DRAM_MASTERS;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

	arb_state_e   state;
	dram_master_e last;  // Slot served most recently
	dram_master_e owner; // Slot holding the lock
	dram_master_e grant;
	logic [N-1:0] req;
	logic         any_req;
	logic         busy;

	assign req  = {ibus_req_valid, dbus_req_valid, gfx_vram_req_valid};
	assign busy = state == ARB_BUSY;

	////////////////////////////////////////////////////////////
	// Round-robin pick with the nearest slot after last winning

	always_comb begin
		int idx;
		grant   = last;
		any_req = 1'b0;
		for (int i = N; i >= 1; i--) begin
			idx = (int'(last) + i) % N;
			if (req[idx]) begin
				grant   = dram_master_e'(idx[1:0]);
				any_req = 1'b1;
			end
		end
	end

	always_comb begin
		case (grant)
			M_GFX_VRAM: begin
				dram_req_op    = gfx_vram_req_op;
				dram_req_addr  = gfx_vram_req_addr;
				dram_req_wdata = gfx_vram_req_wdata;
			end
			M_HOST_DBUS: begin
				dram_req_op    = dbus_req_op;
				dram_req_addr  = dbus_req_addr;
				dram_req_wdata = dbus_req_wdata;
			end
			default: begin
				dram_req_op    = OP_READ; // Instruction fetch
				dram_req_addr  = ibus_req_addr;
				dram_req_wdata = '0;
			end
		endcase
	end

	assign dram_req_valid = !busy && any_req;

	assign gfx_vram_req_ready = dram_req_valid && grant == M_GFX_VRAM && dram_req_ready;
	assign dbus_req_ready     = dram_req_valid && grant == M_HOST_DBUS && dram_req_ready;
	assign ibus_req_ready     = dram_req_valid && grant == M_HOST_IBUS && dram_req_ready;

	////////////////////////////////////////////////////////////
	// Response back to the lock owner

	assign gfx_vram_rsp_valid = busy && owner == M_GFX_VRAM && dram_rsp_valid;
	assign dbus_rsp_valid     = busy && owner == M_HOST_DBUS && dram_rsp_valid;
	assign ibus_rsp_valid     = busy && owner == M_HOST_IBUS && dram_rsp_valid;

	assign gfx_vram_rsp_rdata = dram_rsp_rdata;
	assign gfx_vram_rsp_resp  = dram_rsp_resp;
	assign dbus_rsp_rdata     = dram_rsp_rdata;
	assign dbus_rsp_resp      = dram_rsp_resp;
	assign ibus_rsp_rdata     = dram_rsp_rdata;
	assign ibus_rsp_resp      = dram_rsp_resp;

	always_comb begin
		case (owner)
			M_GFX_VRAM:  dram_rsp_ready = busy && gfx_vram_rsp_ready;
			M_HOST_DBUS: dram_rsp_ready = busy && dbus_rsp_ready;
			default:     dram_rsp_ready = busy && ibus_rsp_ready;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ARB_IDLE;
			owner <= M_GFX_VRAM;
			last  <= M_HOST_IBUS; // Slot 0 first after reset
		end else if (!busy) begin
			if (dram_req_valid && dram_req_ready) begin
				state <= ARB_BUSY;
				owner <= grant;
			end
		end else if (dram_rsp_valid && dram_rsp_ready) begin
			state <= ARB_IDLE;
			last  <= owner;
		end
	end

endmodule

// File: src/w3d_mmio_splitter.sv
`include "w3d_interconnect_cfg.svh"

module w3d_mmio_splitter
(
	input  logic                   clk,
	input  logic                   arst_n,

	input  logic                   mmio_req_valid,
	output logic                   mmio_req_ready,
	input  w3d_bus_pkg::bus_op_e   mmio_req_op,
	input  logic [`W3D_ADDR_W-1:0] mmio_req_addr,
	input  logic [`W3D_DATA_W-1:0] mmio_req_wdata,
	output logic                   mmio_rsp_valid,
	input  logic                   mmio_rsp_ready,
	output logic [`W3D_DATA_W-1:0] mmio_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e mmio_rsp_resp,

	output logic                   gfx_ctrl_req_valid,
	input  logic                   gfx_ctrl_req_ready,
	output w3d_bus_pkg::bus_op_e   gfx_ctrl_req_op,
	output logic [`W3D_ADDR_W-1:0] gfx_ctrl_req_addr,
	output logic [`W3D_DATA_W-1:0] gfx_ctrl_req_wdata,
	input  logic                   gfx_ctrl_rsp_valid,
	output logic                   gfx_ctrl_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] gfx_ctrl_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e gfx_ctrl_rsp_resp,

	output logic                   ext_io_req_valid,
	input  logic                   ext_io_req_ready,
	output w3d_bus_pkg::bus_op_e   ext_io_req_op,
	output logic [`W3D_ADDR_W-1:0] ext_io_req_addr,
	output logic [`W3D_DATA_W-1:0] ext_io_req_wdata,
	input  logic                   ext_io_rsp_valid,
	output logic                   ext_io_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] ext_io_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e ext_io_rsp_resp
);

	import w3d_bus_pkg::*;

	typedef enum logic [1:0] {
		SPL_IDLE,
		SPL_GFX,
		SPL_EXT
	} spl_state_e;

	spl_state_e state;
	logic       idle;
	logic       gfx_hit;
	logic       ext_hit;

	assign idle    = state == SPL_IDLE;
	assign gfx_hit = (mmio_req_addr & `W3D_GFX_MASK) == `W3D_GFX_BASE;
	assign ext_hit = (mmio_req_addr & `W3D_EXT_MASK) == `W3D_EXT_BASE;

	assign gfx_ctrl_req_valid = idle && mmio_req_valid && gfx_hit;
	assign ext_io_req_valid   = idle && mmio_req_valid && ext_hit;
	assign mmio_req_ready     = idle && (gfx_hit ? gfx_ctrl_req_ready :
	                                     ext_hit && ext_io_req_ready);

	assign gfx_ctrl_req_op    = mmio_req_op;
	assign gfx_ctrl_req_addr  = mmio_req_addr;
	assign gfx_ctrl_req_wdata = mmio_req_wdata;
	assign ext_io_req_op      = mmio_req_op;
	assign ext_io_req_addr    = mmio_req_addr;
	assign ext_io_req_wdata   = mmio_req_wdata;

	// Response mux follows the recorded target
	always_comb begin
		mmio_rsp_valid = 1'b0;
		mmio_rsp_rdata = '0;
		mmio_rsp_resp  = RESP_OKAY;
		if (state == SPL_GFX) begin
			mmio_rsp_valid = gfx_ctrl_rsp_valid;
			mmio_rsp_rdata = gfx_ctrl_rsp_rdata;
			mmio_rsp_resp  = gfx_ctrl_rsp_resp;
		end else if (state == SPL_EXT) begin
			mmio_rsp_valid = ext_io_rsp_valid;
			mmio_rsp_rdata = ext_io_rsp_rdata;
			mmio_rsp_resp  = ext_io_rsp_resp;
		end
	end

	assign gfx_ctrl_rsp_ready = state == SPL_GFX && mmio_rsp_ready;
	assign ext_io_rsp_ready   = state == SPL_EXT && mmio_rsp_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= SPL_IDLE;
		end else if (idle) begin
			if (mmio_req_valid && mmio_req_ready)
				state <= gfx_hit ? SPL_GFX : SPL_EXT;
		end else if (mmio_rsp_valid && mmio_rsp_ready) begin
			state <= SPL_IDLE;
		end
	end

endmodule

// File: src/w3d_interconnect.sv
`include "w3d_interconnect_cfg.svh"

module w3d_interconnect
(
	input  logic                   clk,
	input  logic                   arst_n,

	input  logic                   gfx_vram_req_valid,
	output logic                   gfx_vram_req_ready,
	input  w3d_bus_pkg::bus_op_e   gfx_vram_req_op,
	input  logic [`W3D_ADDR_W-1:0] gfx_vram_req_addr,
	input  logic [`W3D_DATA_W-1:0] gfx_vram_req_wdata,
	output logic                   gfx_vram_rsp_valid,
	input  logic                   gfx_vram_rsp_ready,
	output logic [`W3D_DATA_W-1:0] gfx_vram_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e gfx_vram_rsp_resp,

	input  logic                   host_dbus_req_valid,
	output logic                   host_dbus_req_ready,
	input  w3d_bus_pkg::bus_op_e   host_dbus_req_op,
	input  logic [`W3D_ADDR_W-1:0] host_dbus_req_addr,
	input  logic [`W3D_DATA_W-1:0] host_dbus_req_wdata,
	output logic                   host_dbus_rsp_valid,
	input  logic                   host_dbus_rsp_ready,
	output logic [`W3D_DATA_W-1:0] host_dbus_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e host_dbus_rsp_resp,

	input  logic                   host_ibus_req_valid,
	output logic                   host_ibus_req_ready,
	input  logic [`W3D_ADDR_W-1:0] host_ibus_req_addr,
	output logic                   host_ibus_rsp_valid,
	input  logic                   host_ibus_rsp_ready,
	output logic [`W3D_DATA_W-1:0] host_ibus_rsp_rdata,
	output w3d_bus_pkg::bus_resp_e host_ibus_rsp_resp,

	output logic                   dram_req_valid,
	input  logic                   dram_req_ready,
	output w3d_bus_pkg::bus_op_e   dram_req_op,
	output logic [`W3D_ADDR_W-1:0] dram_req_addr,
	output logic [`W3D_DATA_W-1:0] dram_req_wdata,
	input  logic                   dram_rsp_valid,
	output logic                   dram_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] dram_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e dram_rsp_resp,

	output logic                   gfx_ctrl_req_valid,
	input  logic                   gfx_ctrl_req_ready,
	output w3d_bus_pkg::bus_op_e   gfx_ctrl_req_op,
	output logic [`W3D_ADDR_W-1:0] gfx_ctrl_req_addr,
	output logic [`W3D_DATA_W-1:0] gfx_ctrl_req_wdata,
	input  logic                   gfx_ctrl_rsp_valid,
	output logic                   gfx_ctrl_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] gfx_ctrl_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e gfx_ctrl_rsp_resp,

	output logic                   ext_io_req_valid,
	input  logic                   ext_io_req_ready,
	output w3d_bus_pkg::bus_op_e   ext_io_req_op,
	output logic [`W3D_ADDR_W-1:0] ext_io_req_addr,
	output logic [`W3D_DATA_W-1:0] ext_io_req_wdata,
	input  logic                   ext_io_rsp_valid,
	output logic                   ext_io_rsp_ready,
	input  logic [`W3D_DATA_W-1:0] ext_io_rsp_rdata,
	input  w3d_bus_pkg::bus_resp_e ext_io_rsp_resp
);

	import w3d_bus_pkg::*;

	// Host data path into arbiter slot 1
	logic                   dbus_req_valid, dbus_req_ready;
	bus_op_e                dbus_req_op;
	logic [`W3D_ADDR_W-1:0] dbus_req_addr;
	logic [`W3D_DATA_W-1:0] dbus_req_wdata, dbus_rsp_rdata;
	logic                   dbus_rsp_valid, dbus_rsp_ready;
	bus_resp_e              dbus_rsp_resp;

	// Host data path into the MMIO splitter
	logic                   mmio_req_valid, mmio_req_ready;
	bus_op_e                mmio_req_op;
	logic [`W3D_ADDR_W-1:0] mmio_req_addr;
	logic [`W3D_DATA_W-1:0] mmio_req_wdata, mmio_rsp_rdata;
	logic                   mmio_rsp_valid, mmio_rsp_ready;
	bus_resp_e              mmio_rsp_resp;

	w3d_host_decoder decoder_i
	(
		.clk,
		.arst_n,
		.host_req_valid(host_dbus_req_valid),
		.host_req_ready(host_dbus_req_ready),
		.host_req_op(host_dbus_req_op),
		.host_req_addr(host_dbus_req_addr),
		.host_req_wdata(host_dbus_req_wdata),
		.host_rsp_valid(host_dbus_rsp_valid),
		.host_rsp_ready(host_dbus_rsp_ready),
		.host_rsp_rdata(host_dbus_rsp_rdata),
		.host_rsp_resp(host_dbus_rsp_resp),
		.dram_req_valid(dbus_req_valid),
		.dram_req_ready(dbus_req_ready),
		.dram_req_op(dbus_req_op),
		.dram_req_addr(dbus_req_addr),
		.dram_req_wdata(dbus_req_wdata),
		.dram_rsp_valid(dbus_rsp_valid),
		.dram_rsp_ready(dbus_rsp_ready),
		.dram_rsp_rdata(dbus_rsp_rdata),
		.dram_rsp_resp(dbus_rsp_resp),
		.mmio_req_valid, .mmio_req_ready, .mmio_req_op, .mmio_req_addr, .mmio_req_wdata,
		.mmio_rsp_valid, .mmio_rsp_ready, .mmio_rsp_rdata, .mmio_rsp_resp
	);

	w3d_dram_arbiter arbiter_i
	(
		.clk,
		.arst_n,
		.gfx_vram_req_valid, .gfx_vram_req_ready, .gfx_vram_req_op,
		.gfx_vram_req_addr, .gfx_vram_req_wdata,
		.gfx_vram_rsp_valid, .gfx_vram_rsp_ready, .gfx_vram_rsp_rdata, .gfx_vram_rsp_resp,
		.dbus_req_valid, .dbus_req_ready, .dbus_req_op, .dbus_req_addr, .dbus_req_wdata,
		.dbus_rsp_valid, .dbus_rsp_ready, .dbus_rsp_rdata, .dbus_rsp_resp,
		.ibus_req_valid(host_ibus_req_valid),
		.ibus_req_ready(host_ibus_req_ready),
		.ibus_req_addr(host_ibus_req_addr),
		.ibus_rsp_valid(host_ibus_rsp_valid),
		.ibus_rsp_ready(host_ibus_rsp_ready),
		.ibus_rsp_rdata(host_ibus_rsp_rdata),
		.ibus_rsp_resp(host_ibus_rsp_resp),
		.dram_req_valid, .dram_req_ready, .dram_req_op, .dram_req_addr, .dram_req_wdata,
		.dram_rsp_valid, .dram_rsp_ready, .dram_rsp_rdata, .dram_rsp_resp
	);

	w3d_mmio_splitter splitter_i
	(
		.clk,
		.arst_n,
		.mmio_req_valid, .mmio_req_ready, .mmio_req_op, .mmio_req_addr, .mmio_req_wdata,
		.mmio_rsp_valid, .mmio_rsp_ready, .mmio_rsp_rdata, .mmio_rsp_resp,
		.gfx_ctrl_req_valid, .gfx_ctrl_req_ready, .gfx_ctrl_req_op,
		.gfx_ctrl_req_addr, .gfx_ctrl_req_wdata,
		.gfx_ctrl_rsp_valid, .gfx_ctrl_rsp_ready, .gfx_ctrl_rsp_rdata, .gfx_ctrl_rsp_resp,
		.ext_io_req_valid, .ext_io_req_ready, .ext_io_req_op,
		.ext_io_req_addr, .ext_io_req_wdata,
		.ext_io_rsp_valid, .ext_io_rsp_ready, .ext_io_rsp_rdata, .ext_io_rsp_resp
	);

endmodule

// File: sim/tb_w3d_interconnect.sv
`include "w3d_interconnect_cfg.svh"

module tb_w3d_interconnect;

	import w3d_bus_pkg::*;

	localparam int NUM_TXN  = 400;
	localparam int CYCLE    = 20;
	localparam int DRIVE_AT = 2;
	localparam int SAMPLE_AT = CYCLE - 2; // Just before the next rising edge
	localparam int MAX_WAIT = 200;

	logic clk;
	logic arst_n;

	logic                   gfx_vram_req_valid, gfx_vram_req_ready;
	logic                   gfx_vram_rsp_valid, gfx_vram_rsp_ready;
	bus_op_e                gfx_vram_req_op;
	logic [`W3D_ADDR_W-1:0] gfx_vram_req_addr;
	logic [`W3D_DATA_W-1:0] gfx_vram_req_wdata, gfx_vram_rsp_rdata;
	bus_resp_e              gfx_vram_rsp_resp;

	logic                   host_dbus_req_valid, host_dbus_req_ready;
	logic                   host_dbus_rsp_valid, host_dbus_rsp_ready;
	bus_op_e                host_dbus_req_op;
	logic [`W3D_ADDR_W-1:0] host_dbus_req_addr;
	logic [`W3D_DATA_W-1:0] host_dbus_req_wdata, host_dbus_rsp_rdata;
	bus_resp_e              host_dbus_rsp_resp;

	logic                   host_ibus_req_valid, host_ibus_req_ready;
	logic                   host_ibus_rsp_valid, host_ibus_rsp_ready;
	logic [`W3D_ADDR_W-1:0] host_ibus_req_addr;
	logic [`W3D_DATA_W-1:0] host_ibus_rsp_rdata;
	bus_resp_e              host_ibus_rsp_resp;

	logic                   dram_req_valid, dram_req_ready;
	logic                   dram_rsp_valid, dram_rsp_ready;
	bus_op_e                dram_req_op;
	logic [`W3D_ADDR_W-1:0] dram_req_addr;
	logic [`W3D_DATA_W-1:0] dram_req_wdata, dram_rsp_rdata;
	bus_resp_e              dram_rsp_resp;

	logic                   gfx_ctrl_req_valid, gfx_ctrl_req_ready;
	logic                   gfx_ctrl_rsp_valid, gfx_ctrl_rsp_ready;
	bus_op_e                gfx_ctrl_req_op;
	logic [`W3D_ADDR_W-1:0] gfx_ctrl_req_addr;
	logic [`W3D_DATA_W-1:0] gfx_ctrl_req_wdata, gfx_ctrl_rsp_rdata;
	bus_resp_e              gfx_ctrl_rsp_resp;

	logic                   ext_io_req_valid, ext_io_req_ready;
	logic                   ext_io_rsp_valid, ext_io_rsp_ready;
	bus_op_e                ext_io_req_op;
	logic [`W3D_ADDR_W-1:0] ext_io_req_addr;
	logic [`W3D_DATA_W-1:0] ext_io_req_wdata, ext_io_rsp_rdata;
	bus_resp_e              ext_io_rsp_resp;

	// Master slots 0 gfx_vram, 1 host_dbus, 2 host_ibus
	logic        m_active    [0:2]; // Request offered
	logic        m_wait      [0:2]; // Response owed
	logic        m_rsp_ready [0:2];
	bus_op_e     m_op        [0:2];
	logic [31:0] m_addr      [0:2];
	logic [31:0] m_wdata     [0:2];
	logic [31:0] exp_rdata   [0:2];
	bus_resp_e   exp_resp    [0:2];
	int          m_age       [0:2];
	logic        m_req_ready [0:2];
	logic        m_rsp_valid [0:2];
	logic [31:0] m_rsp_rdata [0:2];
	bus_resp_e   m_rsp_resp  [0:2];

	// Slave ports 0 dram, 1 gfx_ctrl, 2 ext_io
	logic        s_req_ready [0:2];
	logic        s_busy      [0:2];
	logic        s_rsp_valid [0:2];
	logic [31:0] s_rdata     [0:2];
	int          s_delay     [0:2];
	logic        s_req_valid [0:2];
	bus_op_e     s_req_op    [0:2];
	logic [31:0] s_req_addr  [0:2];
	logic [31:0] s_req_wdata [0:2];
	logic        s_rsp_ready [0:2];

	logic [31:0] slave_mem [0:2][0:1023];
	logic [31:0] ref_mem   [0:2][0:1023]; // Last written value per address
	logic [15:0] lfsr;
	int          issued;
	int          done;
	int          last_served;
	int          mismatch_errors;
	int          other_errors;

	w3d_interconnect dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CYCLE / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Random bits and address map

	function automatic logic lfsr_step();
		logic lsb;
		lsb  = lfsr[0];
		lfsr = (lfsr >> 1) ^ (lsb ? 16'hb400 : 16'h0000);
		return lsb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	function automatic int target_of(input logic [31:0] a);
		if (a[31:29] == 3'b000)
			return 0;
		else if (a[31:28] == 4'h2)
			return 1;
		else if (a[31:28] == 4'h3)
			return 2;
		else
			return 3; // Unmapped
	endfunction

	function automatic int word_of(input int t, input logic [31:0] a);
		return (t == 0) ? int'(a[11:2]) : int'(a[5:2]);
	endfunction

	function automatic logic port_ok(input int s, input logic [31:0] a);
		if (target_of(a) != s)
			return 1'b0;
		return s != 0 || (a[28:12] == '0 && a[11:10] != 2'b11);
	endfunction

	////////////////////////////////////////////////////////////
	// Port access

	task automatic drive_ports();
		gfx_vram_req_valid  = m_active[0];
		gfx_vram_req_op     = m_op[0];
		gfx_vram_req_addr   = m_addr[0];
		gfx_vram_req_wdata  = m_wdata[0];
		gfx_vram_rsp_ready  = m_rsp_ready[0];
		host_dbus_req_valid = m_active[1];
		host_dbus_req_op    = m_op[1];
		host_dbus_req_addr  = m_addr[1];
		host_dbus_req_wdata = m_wdata[1];
		host_dbus_rsp_ready = m_rsp_ready[1];
		host_ibus_req_valid = m_active[2];
		host_ibus_req_addr  = m_addr[2];
		host_ibus_rsp_ready = m_rsp_ready[2];
		dram_req_ready      = s_req_ready[0];
		dram_rsp_valid      = s_rsp_valid[0];
		dram_rsp_rdata      = s_rdata[0];
		dram_rsp_resp       = RESP_OKAY;
		gfx_ctrl_req_ready  = s_req_ready[1];
		gfx_ctrl_rsp_valid  = s_rsp_valid[1];
		gfx_ctrl_rsp_rdata  = s_rdata[1];
		gfx_ctrl_rsp_resp   = RESP_OKAY;
		ext_io_req_ready    = s_req_ready[2];
		ext_io_rsp_valid    = s_rsp_valid[2];
		ext_io_rsp_rdata    = s_rdata[2];
		ext_io_rsp_resp     = RESP_OKAY;
	endtask

	task automatic sample_ports();
		m_req_ready[0] = gfx_vram_req_ready;
		m_req_ready[1] = host_dbus_req_ready;
		m_req_ready[2] = host_ibus_req_ready;
		m_rsp_valid[0] = gfx_vram_rsp_valid;
		m_rsp_valid[1] = host_dbus_rsp_valid;
		m_rsp_valid[2] = host_ibus_rsp_valid;
		m_rsp_rdata[0] = gfx_vram_rsp_rdata;
		m_rsp_rdata[1] = host_dbus_rsp_rdata;
		m_rsp_rdata[2] = host_ibus_rsp_rdata;
		m_rsp_resp[0]  = gfx_vram_rsp_resp;
		m_rsp_resp[1]  = host_dbus_rsp_resp;
		m_rsp_resp[2]  = host_ibus_rsp_resp;
		s_req_valid[0] = dram_req_valid;
		s_req_valid[1] = gfx_ctrl_req_valid;
		s_req_valid[2] = ext_io_req_valid;
		s_req_op[0]    = dram_req_op;
		s_req_op[1]    = gfx_ctrl_req_op;
		s_req_op[2]    = ext_io_req_op;
		s_req_addr[0]  = dram_req_addr;
		s_req_addr[1]  = gfx_ctrl_req_addr;
		s_req_addr[2]  = ext_io_req_addr;
		s_req_wdata[0] = dram_req_wdata;
		s_req_wdata[1] = gfx_ctrl_req_wdata;
		s_req_wdata[2] = ext_io_req_wdata;
		s_rsp_ready[0] = dram_rsp_ready;
		s_rsp_ready[1] = gfx_ctrl_rsp_ready;
		s_rsp_ready[2] = ext_io_rsp_ready;
	endtask

	task automatic init_models();
		lfsr            = 16'd12720;
		issued          = 0;
		done            = 0;
		last_served     = 2; // Slot 0 is first after reset
		mismatch_errors = 0;
		other_errors    = 0;
		for (int t = 0; t < 3; t++) begin
			for (int w = 0; w < 1024; w++) begin
				slave_mem[t][w] = '0;
				ref_mem[t][w]   = '0;
			end
			m_active[t]    = 1'b0;
			m_wait[t]      = 1'b0;
			m_rsp_ready[t] = 1'b0;
			m_op[t]        = OP_READ;
			m_addr[t]      = '0;
			m_wdata[t]     = '0;
			m_age[t]       = 0;
			s_req_ready[t] = 1'b0;
			s_busy[t]      = 1'b0;
			s_rsp_valid[t] = 1'b0;
			s_rdata[t]     = '0;
			s_delay[t]     = 0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	task automatic new_request(input int i);
		logic [31:0] r;
		logic [31:0] k;
		r          = rand_bits(8);
		m_op[i]    = OP_READ;
		m_wdata[i] = rand_bits(32);
		m_addr[i]  = {20'h0, 2'(i), r[7:0], 2'b00}; // Own DRAM window
		if (i != 2)
			m_op[i] = bus_op_e'(lfsr_step());
		if (i == 1) begin
			k = rand_bits(2);
			if (k[1:0] == 2'd2) begin
				r         = rand_bits(13);
				m_addr[i] = {3'b001, r[12], r[11:4], 14'h0, r[3:0], 2'b00}; // GFX or EXT
			end else if (k[1:0] == 2'd3) begin
				r         = rand_bits(32);
				m_addr[i] = r | 32'h4000_0000; // Unmapped
			end
		end
	endtask

	task automatic step_stimulus();
		for (int i = 0; i < 3; i++) begin
			if (!m_active[i] && !m_wait[i] && issued < NUM_TXN) begin
				if (lfsr_step()) begin
					new_request(i);
					m_active[i] = 1'b1;
					m_age[i]    = 0;
					issued++;
				end
			end
			m_rsp_ready[i] = lfsr_step();
		end
		for (int s = 0; s < 3; s++) begin
			if (s_busy[s]) begin
				s_req_ready[s] = 1'b0;
				if (!s_rsp_valid[s]) begin
					if (s_delay[s] == 0)
						s_rsp_valid[s] = 1'b1;
					else
						s_delay[s]--;
				end
			end else begin
				s_req_ready[s] = lfsr_step();
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Checks and models

	task automatic check_dram_grant();
		logic pend [0:2];
		int   slot;
		int   want;
		int   j;
		slot    = int'(s_req_addr[0][11:10]);
		pend[0] = m_active[0];
		pend[1] = m_active[1] && target_of(m_addr[1]) == 0;
		pend[2] = m_active[2];
		want    = -1;
		// First pending slot after the one served before
		for (int k = 1; k <= 3; k++) begin
			j = (last_served + k) % 3;
			if (want < 0 && pend[j])
				want = j;
		end
		assert (slot == want) else begin
			mismatch_errors++;
			$display("mismatch at %0t: DRAM granted slot %0d, expected slot %0d",
				$time, slot, want);
		end
		if (slot <= 2) begin
			assert (m_active[slot] && s_req_op[0] == m_op[slot] && s_req_addr[0] == m_addr[slot]
				&& (m_op[slot] == OP_READ || s_req_wdata[0] == m_wdata[slot])) else begin
				mismatch_errors++;
				$display("mismatch at %0t: DRAM request %s %h %h differs from slot %0d",
					$time, s_req_op[0].name(), s_req_addr[0], s_req_wdata[0], slot);
			end
			last_served = slot;
		end
	endtask

	task automatic check_mmio_request(input int s);
		assert (m_active[1] && s_req_addr[s] == m_addr[1] && s_req_op[s] == m_op[1]
			&& (m_op[1] == OP_READ || s_req_wdata[s] == m_wdata[1])) else begin
			mismatch_errors++;
			$display("mismatch at %0t: slave %0d request %h does not match host data %h",
				$time, s, s_req_addr[s], m_addr[1]);
		end
	endtask

	task automatic slave_accept(input int s);
		int w;
		w = word_of(s, s_req_addr[s]);
		if (s == 0)
			check_dram_grant();
		else
			check_mmio_request(s);
		s_rdata[s] = '0; // Write responses carry zero data
		if (s_req_op[s] == OP_WRITE)
			slave_mem[s][w] = s_req_wdata[s];
		else
			s_rdata[s] = slave_mem[s][w];
		s_busy[s]  = 1'b1;
		s_delay[s] = int'(rand_bits(2));
	endtask

	task automatic master_accept(input int i);
		int t;
		int w;
		t            = target_of(m_addr[i]);
		w            = word_of(t, m_addr[i]);
		exp_rdata[i] = '0;
		exp_resp[i]  = RESP_OKAY;
		if (t == 3)
			exp_resp[i] = RESP_DECERR;
		else if (m_op[i] == OP_WRITE)
			ref_mem[t][w] = m_wdata[i];
		else
			exp_rdata[i] = ref_mem[t][w];
		m_active[i] = 1'b0;
		m_wait[i]   = 1'b1;
	endtask

	task automatic check_ports();
		for (int s = 0; s < 3; s++) begin
			assert (!s_req_valid[s] || port_ok(s, s_req_addr[s])) else begin
				other_errors++;
				$display("A request for address %h showed up at slave port %0d at %0t",
					s_req_addr[s], s, $time);
			end
		end
	endtask

	task automatic process_handshakes();
		for (int s = 0; s < 3; s++) begin
			if (s_req_valid[s] && s_req_ready[s])
				slave_accept(s);
			if (s_rsp_valid[s] && s_rsp_ready[s]) begin
				s_busy[s]      = 1'b0;
				s_rsp_valid[s] = 1'b0;
			end
		end
		for (int i = 0; i < 3; i++) begin
			if (m_active[i] && m_req_ready[i])
				master_accept(i);
			assert (!m_rsp_valid[i] || m_wait[i]) else begin
				other_errors++;
				$display("Master %0d saw a response with nothing outstanding at %0t", i, $time);
			end
			if (m_wait[i] && m_rsp_valid[i] && m_rsp_ready[i]) begin
				assert (m_rsp_rdata[i] == exp_rdata[i] && m_rsp_resp[i] == exp_resp[i]) else begin
					mismatch_errors++;
					$display("mismatch at %0t: master %0d addr %h got %h %s, expected %h %s",
						$time, i, m_addr[i], m_rsp_rdata[i], m_rsp_resp[i].name(),
						exp_rdata[i], exp_resp[i].name());
				end
				m_wait[i] = 1'b0;
				done++;
			end
			if (m_active[i] || m_wait[i])
				m_age[i]++;
			assert (m_age[i] != MAX_WAIT) else begin
				other_errors++;
				$display("Master %0d got no response within %0d cycles at %0t",
					i, MAX_WAIT, $time);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		init_models();
		drive_ports();
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		#DRIVE_AT;
		arst_n = 1'b1;
		#(SAMPLE_AT - DRIVE_AT);
		sample_ports();
		assert (!gfx_vram_rsp_valid && !host_dbus_rsp_valid && !host_ibus_rsp_valid
			&& !dram_req_valid && !gfx_ctrl_req_valid && !ext_io_req_valid) else begin
			other_errors++;
			$display("A valid output was high after reset with no stimulus at %0t", $time);
		end
		while (done < NUM_TXN) begin
			@(posedge clk);
			#DRIVE_AT;
			step_stimulus();
			drive_ports();
			#(SAMPLE_AT - DRIVE_AT);
			sample_ports();
			check_ports();
			process_handshakes();
		end
		repeat (2) @(posedge clk);
		$display("Error count: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(NUM_TXN * 40 * CYCLE);
		$display("Watchdog expired with %0d of %0d transactions done", done, NUM_TXN);
		$display("Error count: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+src
src/w3d_bus_pkg.sv
src/w3d_map_pkg.sv
src/w3d_host_decoder.sv
src/w3d_dram_arbiter.sv
src/w3d_mmio_splitter.sv
src/w3d_interconnect.sv
sim/tb_w3d_interconnect.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the interconnect testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module tb_w3d_interconnect \
	-f tb.f \
	-o tb_w3d_interconnect

./obj_dir/tb_w3d_interconnect | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi
echo "PASS"
